// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// data and address width
	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t;
	typedef logic [xlen-1:0] word_t;

	// major opcodes encoded as the low seven instruction bits
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

// File: verilog/pipe_if.sv
`timescale 1ns/10ps
`default_nettype none

// execute to memory bundle that the forwarding logic also reads
interface ex_mem_if ();
	rv_pkg::word_t alu_result;
	rv_pkg::word_t store_data;
	rv_pkg::reg_idx_t rd;
	logic reg_write;
	logic mem_read;
	logic mem_write;

	modport producer (output alu_result, store_data, rd, reg_write, mem_read, mem_write);
	modport consumer (input alu_result, store_data, rd, reg_write, mem_read, mem_write);
endinterface

// register file write port
interface wb_if ();
	logic wb_en;
	rv_pkg::reg_idx_t wb_rd;
	rv_pkg::word_t wb_data;

	modport source (output wb_en, wb_rd, wb_data);
	modport sink (input wb_en, wb_rd, wb_data);
endinterface

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
	parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  wire logic     clock,
	input  wire logic     reset,
	input  rv_pkg::word_t instr_in,
	input  wire logic     stall,
	input  wire logic     redirect,
	input  rv_pkg::word_t target,
	output rv_pkg::word_t pc_out,
	output rv_pkg::word_t ifid_pc,
	output rv_pkg::word_t ifid_instr
);

	// redirect wins over stall
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc_out <= reset_pc;
			ifid_instr <= rv_pkg::nop_instr;
		end else if (redirect) begin
			pc_out <= target;
			ifid_instr <= rv_pkg::nop_instr;
		end else if (!stall) begin
			pc_out <= pc_out + 32'd4;
			ifid_instr <= instr_in;
		end
	end

	always_ff @(posedge clock) begin
		if (redirect || !stall) begin
			ifid_pc <= pc_out;
		end
	end

	// branch and jal targets must keep the pc on a word boundary
	pc_aligned: assert property (@(posedge clock) disable iff (!reset)
		pc_out[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  wire logic        clock,
	input  wire logic        reset,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	wb_if.sink               wb,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clock) begin
		if (wb.wb_en && wb.wb_rd != 5'd0) begin
			regs[wb.wb_rd] <= wb.wb_data;
		end
	end

	// x0 reads zero and a same-cycle write passes straight through
	always_comb begin
		if (rs1 == 5'd0) begin
			rs1_data = '0;
		end else if (wb.wb_en && wb.wb_rd == rs1) begin
			rs1_data = wb.wb_data;
		end else begin
			rs1_data = regs[rs1];
		end
	end

	always_comb begin
		if (rs2 == 5'd0) begin
			rs2_data = '0;
		end else if (wb.wb_en && wb.wb_rd == rs2) begin
			rs2_data = wb.wb_data;
		end else begin
			rs2_data = regs[rs2];
		end
	end

	wb_rd_known: assert property (@(posedge clock) disable iff (!reset)
		wb.wb_en |-> !$isunknown(wb.wb_rd));

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  wire logic         clock,
	input  wire logic         reset,
	input  rv_pkg::word_t     ifid_pc,
	input  rv_pkg::word_t     ifid_instr,
	input  rv_pkg::word_t     rs1_data,
	input  rv_pkg::word_t     rs2_data,
	input  wire logic         redirect,
	input  wire logic         idex_mem_read,
	input  rv_pkg::reg_idx_t  idex_rd,
	output rv_pkg::reg_idx_t  rs1,
	output rv_pkg::reg_idx_t  rs2,
	output logic              stall,
	output rv_pkg::word_t     ex_pc,
	output rv_pkg::word_t     ex_rs1_data,
	output rv_pkg::word_t     ex_rs2_data,
	output rv_pkg::reg_idx_t  ex_rs1,
	output rv_pkg::reg_idx_t  ex_rs2,
	output rv_pkg::reg_idx_t  ex_rd,
	output rv_pkg::word_t     ex_imm,
	output rv_pkg::alu_op_e   ex_alu_op,
	output rv_pkg::opcode_e   ex_opcode,
	output logic              ex_reg_write,
	output logic              ex_mem_read,
	output logic              ex_mem_write
);

	rv_pkg::opcode_e opcode;
	rv_pkg::alu_op_e alu_op;
	rv_pkg::word_t imm;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic uses_rs1;
	logic uses_rs2;
	logic bubble;

	assign rs1 = ifid_instr[19:15];
	assign rs2 = ifid_instr[24:20];

	////////////////////////////////////////////////////////////
	// control and immediate decode
	////////////////////////////////////////////////////////////
	always_comb begin
		opcode = rv_pkg::op_imm;
		alu_op = rv_pkg::alu_add;
		imm = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		uses_rs1 = 1'b1;
		uses_rs2 = 1'b0;
		case (ifid_instr[6:0])
			rv_pkg::op_reg: begin
				opcode = rv_pkg::op_reg;
				reg_write = 1'b1;
				uses_rs2 = 1'b1;
				// funct7 bit 5 with funct3
				case ({ifid_instr[30], ifid_instr[14:12]})
					4'b1000: alu_op = rv_pkg::alu_sub;
					4'b0111: alu_op = rv_pkg::alu_and;
					4'b0110: alu_op = rv_pkg::alu_or;
					4'b0100: alu_op = rv_pkg::alu_xor;
					4'b0010: alu_op = rv_pkg::alu_slt;
					default: alu_op = rv_pkg::alu_add;
				endcase
			end
			rv_pkg::op_imm: begin
				reg_write = 1'b1;
			end
			rv_pkg::op_load: begin
				opcode = rv_pkg::op_load;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			rv_pkg::op_store: begin
				opcode = rv_pkg::op_store;
				mem_write = 1'b1;
				uses_rs2 = 1'b1;
				imm = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
			end
			rv_pkg::op_branch: begin
				opcode = rv_pkg::op_branch;
				uses_rs2 = 1'b1;
				imm = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
					ifid_instr[30:25], ifid_instr[11:8], 1'b0};
			end
			rv_pkg::op_jal: begin
				opcode = rv_pkg::op_jal;
				reg_write = 1'b1;
				uses_rs1 = 1'b0;
				imm = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
					ifid_instr[20], ifid_instr[30:21], 1'b0};
			end
			default: begin
				uses_rs1 = 1'b0;
			end
		endcase
	end

	// load in execute feeding a source here costs one cycle
	assign stall = idex_mem_read && idex_rd != 5'd0 &&
		((uses_rs1 && idex_rd == rs1) || (uses_rs2 && idex_rd == rs2));
	assign bubble = stall || redirect;

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_opcode <= rv_pkg::op_imm;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else if (bubble) begin
			ex_opcode <= rv_pkg::op_imm;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_opcode <= opcode;
			ex_reg_write <= reg_write;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
		end
	end

	// operands and fields pass through unchanged on a bubble
	always_ff @(posedge clock) begin
		ex_pc <= ifid_pc;
		ex_rs1_data <= rs1_data;
		ex_rs2_data <= rs2_data;
		ex_rs1 <= rs1;
		ex_rs2 <= rs2;
		ex_rd <= ifid_instr[11:7];
		ex_imm <= imm;
		ex_alu_op <= alu_op;
	end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  wire logic         clock,
	input  wire logic         reset,
	input  rv_pkg::word_t     ex_pc,
	input  rv_pkg::word_t     ex_rs1_data,
	input  rv_pkg::word_t     ex_rs2_data,
	input  rv_pkg::reg_idx_t  ex_rs1,
	input  rv_pkg::reg_idx_t  ex_rs2,
	input  rv_pkg::reg_idx_t  ex_rd,
	input  rv_pkg::word_t     ex_imm,
	input  rv_pkg::alu_op_e   ex_alu_op,
	input  rv_pkg::opcode_e   ex_opcode,
	input  wire logic         ex_reg_write,
	input  wire logic         ex_mem_read,
	input  wire logic         ex_mem_write,
	ex_mem_if.producer        exm,
	wb_if.sink                wb,
	output logic              redirect,
	output rv_pkg::word_t     target,
	output logic              idex_mem_read,
	output rv_pkg::reg_idx_t  idex_rd
);

	rv_pkg::word_t fwd_a;
	rv_pkg::word_t fwd_b;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_out;
	rv_pkg::word_t result;

	// seen by decode for load-use detection
	assign idex_mem_read = ex_mem_read;
	assign idex_rd = ex_rd;

	////////////////////////////////////////////////////////////
	// forwarding with EX/MEM ahead of writeback
	////////////////////////////////////////////////////////////
	always_comb begin
		if (exm.reg_write && !exm.mem_read && exm.rd != 5'd0 && exm.rd == ex_rs1) begin
			fwd_a = exm.alu_result;
		end else if (wb.wb_en && wb.wb_rd == ex_rs1) begin
			fwd_a = wb.wb_data;
		end else begin
			fwd_a = ex_rs1_data;
		end
	end

	always_comb begin
		if (exm.reg_write && !exm.mem_read && exm.rd != 5'd0 && exm.rd == ex_rs2) begin
			fwd_b = exm.alu_result;
		end else if (wb.wb_en && wb.wb_rd == ex_rs2) begin
			fwd_b = wb.wb_data;
		end else begin
			fwd_b = ex_rs2_data;
		end
	end

	// only R-type takes rs2 as the second operand
	assign op_b = (ex_opcode == rv_pkg::op_reg) ? fwd_b : ex_imm;

	always_comb begin
		case (ex_alu_op)
			rv_pkg::alu_sub: alu_out = fwd_a - op_b;
			rv_pkg::alu_and: alu_out = fwd_a & op_b;
			rv_pkg::alu_or:  alu_out = fwd_a | op_b;
			rv_pkg::alu_xor: alu_out = fwd_a ^ op_b;
			rv_pkg::alu_slt: alu_out = {31'd0, $signed(fwd_a) < $signed(op_b)};
			default:         alu_out = fwd_a + op_b;
		endcase
	end

	// jal links pc + 4
	assign result = (ex_opcode == rv_pkg::op_jal) ? ex_pc + 32'd4 : alu_out;

	assign redirect = (ex_opcode == rv_pkg::op_jal) ||
		(ex_opcode == rv_pkg::op_branch && fwd_a == fwd_b);
	assign target = ex_pc + ex_imm;

	////////////////////////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exm.reg_write <= 1'b0;
			exm.mem_read <= 1'b0;
			exm.mem_write <= 1'b0;
		end else begin
			exm.reg_write <= ex_reg_write;
			exm.mem_read <= ex_mem_read;
			exm.mem_write <= ex_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		exm.alu_result <= result;
		exm.store_data <= fwd_b;
		exm.rd <= ex_rd;
	end

	mem_access_onehot: assert property (@(posedge clock) disable iff (!reset)
		!(exm.mem_read && exm.mem_write));

endmodule

`default_nettype wire

// File: verilog/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
	input  wire logic     clock,
	input  wire logic     reset,
	input  rv_pkg::word_t data_in,
	ex_mem_if.consumer    exm,
	wb_if.source          wb
);

	logic reg_write;
	rv_pkg::reg_idx_t rd;
	rv_pkg::word_t data;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			reg_write <= 1'b0;
		end else begin
			reg_write <= exm.reg_write;
		end
	end

	// loaded word or alu result
	always_ff @(posedge clock) begin
		rd <= exm.rd;
		data <= exm.mem_read ? data_in : exm.alu_result;
	end

	// x0 is never written
	assign wb.wb_en = reg_write && rd != 5'd0;
	assign wb.wb_rd = rd;
	assign wb.wb_data = data;

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  wire logic          clock,
	input  wire logic          reset,
	output rv_pkg::word_t      pc_out,
	input  rv_pkg::word_t      instr_in,
	output rv_pkg::word_t      data_addr,
	output logic               ren,
	output logic               wen,
	output rv_pkg::word_t      data_out,
	input  rv_pkg::word_t      data_in
);

	logic stall;
	logic redirect;
	rv_pkg::word_t target;
	rv_pkg::word_t ifid_pc;
	rv_pkg::word_t ifid_instr;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	logic idex_mem_read;
	rv_pkg::reg_idx_t idex_rd;

	// ID/EX contents
	rv_pkg::word_t ex_pc;
	rv_pkg::word_t ex_rs1_data;
	rv_pkg::word_t ex_rs2_data;
	rv_pkg::reg_idx_t ex_rs1;
	rv_pkg::reg_idx_t ex_rs2;
	rv_pkg::reg_idx_t ex_rd;
	rv_pkg::word_t ex_imm;
	rv_pkg::alu_op_e ex_alu_op;
	rv_pkg::opcode_e ex_opcode;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;

	ex_mem_if exm_bus ();
	wb_if wb_bus ();

	////////////////////////////////////////////////////////////
	// data memory port driven straight from EX/MEM
	////////////////////////////////////////////////////////////
	assign data_addr = exm_bus.alu_result;
	assign data_out  = exm_bus.store_data;
	assign ren       = exm_bus.mem_read;
	assign wen       = exm_bus.mem_write;

	fetch_stage #(.reset_pc(reset_pc)) fetch_i (
		.clock(clock), .reset(reset), .instr_in(instr_in), .stall(stall),
		.redirect(redirect), .target(target), .pc_out(pc_out),
		.ifid_pc(ifid_pc), .ifid_instr(ifid_instr)
	);

	reg_file regs_i (
		.clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .wb(wb_bus.sink),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	decode_stage decode_i (
		.clock(clock), .reset(reset), .ifid_pc(ifid_pc), .ifid_instr(ifid_instr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .redirect(redirect),
		.idex_mem_read(idex_mem_read), .idex_rd(idex_rd), .rs1(rs1), .rs2(rs2),
		.stall(stall), .ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data),
		.ex_rs2_data(ex_rs2_data), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_imm(ex_imm), .ex_alu_op(ex_alu_op), .ex_opcode(ex_opcode),
		.ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write)
	);

	execute_stage execute_i (
		.clock(clock), .reset(reset), .ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data),
		.ex_rs2_data(ex_rs2_data), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_imm(ex_imm), .ex_alu_op(ex_alu_op), .ex_opcode(ex_opcode),
		.ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .exm(exm_bus.producer), .wb(wb_bus.sink),
		.redirect(redirect), .target(target), .idex_mem_read(idex_mem_read),
		.idex_rd(idex_rd)
	);

	mem_wb_stage mem_wb_i (
		.clock(clock), .reset(reset), .data_in(data_in), .exm(exm_bus.consumer),
		.wb(wb_bus.source)
	);

endmodule

`default_nettype wire

// File: tb/core_checker.sv
`timescale 1ns/10ps
`default_nettype none

module core_checker (
	input wire logic     clock,
	input wire logic     reset,
	input wire logic     wen,
	input rv_pkg::word_t data_addr,
	input rv_pkg::word_t data_out
);

	localparam int depth = 64;

	// expected stores in program order
	string exp_name [depth];
	rv_pkg::word_t exp_addr [depth];
	rv_pkg::word_t exp_data [depth];
	int wr_ptr = 0;
	int rd_ptr = 0;
	int pass_count = 0;
	int fail_count = 0;

	task automatic add_expect(input string name, input rv_pkg::word_t addr,
		input rv_pkg::word_t data);
		if (wr_ptr == depth) begin
			$display("expected store list is full, test %s dropped", name);
			fail_count++;
		end else begin
			exp_name[wr_ptr] = name;
			exp_addr[wr_ptr] = addr;
			exp_data[wr_ptr] = data;
			wr_ptr++;
		end
	endtask

	function automatic int pending();
		pending = wr_ptr - rd_ptr;
	endfunction

	// tests still waiting for their store
	task automatic report_missing();
		while (rd_ptr < wr_ptr) begin
			$display("test %s never stored to address %h", exp_name[rd_ptr],
				exp_addr[rd_ptr]);
			fail_count++;
			rd_ptr++;
		end
	endtask

	task automatic check_store();
		if (rd_ptr == wr_ptr) begin
			$display("unexpected store of %h to address %h, no test was waiting for it",
				data_out, data_addr);
			fail_count++;
		end else if (data_addr !== exp_addr[rd_ptr] || data_out !== exp_data[rd_ptr]) begin
			$display("** Error %s: expected addr %h data %h, got addr %h data %h",
				exp_name[rd_ptr], exp_addr[rd_ptr], exp_data[rd_ptr], data_addr, data_out);
			fail_count++;
			rd_ptr++;
		end else begin
			$display("pass %s: addr %h data %h", exp_name[rd_ptr], data_addr, data_out);
			pass_count++;
			rd_ptr++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// store port sampled mid cycle
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (reset && wen) begin
			check_store();
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;

	localparam rv_pkg::word_t start_pc = 32'h0000_0000;
	localparam int timeout_cycles = 400;
	localparam int drain_cycles = 20;

	logic clock;
	logic reset;
	rv_pkg::word_t pc_out;
	rv_pkg::word_t instr_in;
	rv_pkg::word_t data_addr;
	rv_pkg::word_t data_out;
	rv_pkg::word_t data_in;
	logic ren;
	logic wen;

	rv_pkg::word_t imem [256];
	rv_pkg::word_t dmem [256];
	int n_expect;
	bit stim_ok;
	int cycles;

	rv_core #(.reset_pc(start_pc)) dut_i (
		.clock(clock), .reset(reset), .pc_out(pc_out), .instr_in(instr_in),
		.data_addr(data_addr), .ren(ren), .wen(wen), .data_out(data_out),
		.data_in(data_in)
	);

	core_checker chk_i (
		.clock(clock), .reset(reset), .wen(wen), .data_addr(data_addr),
		.data_out(data_out)
	);

	////////////////////////////////////////////////////////////
	// memory models read in the same cycle
	////////////////////////////////////////////////////////////
	assign instr_in = imem[pc_out[9:2]];

	// data reads only answer while ren is high
	assign data_in = ren ? dmem[data_addr[9:2]] : 'x;

	always @(posedge clock) begin
		if (wen) begin
			dmem[data_addr[9:2]] <= data_out;
		end
	end

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// program, data and expected stores
	task automatic load_stim();
		int fd;
		int n;
		int n_instr;
		string line;
		string kind;
		string name;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		n_instr = 0;
		fd = $fopen("tb/core_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/core_stim.txt");
			stim_ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				kind = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%s", kind);
				if (kind == "i" && n_instr < 256) begin
					n = $sscanf(line, "%s %h", kind, a);
					imem[n_instr] = a;
					n_instr++;
				end else if (kind == "d") begin
					n = $sscanf(line, "%s %h %h", kind, a, b);
					dmem[a[9:2]] = b;
				end else if (kind == "e") begin
					n = $sscanf(line, "%s %s %h %h", kind, name, a, b);
					chk_i.add_expect(name, a, b);
					n_expect++;
				end
			end
			$fclose(fd);
		end
		if (n_expect == 0) begin
			$display("no expected stores were read from the stim file");
			stim_ok = 1'b0;
		end
	endtask

	initial begin
		reset = 1'b0;
		stim_ok = 1'b1;
		n_expect = 0;
		load_stim();
		repeat (4) @(posedge clock);
		#1 reset = 1'b1;

		// run until every expected store has been seen
		cycles = 0;
		while (chk_i.pending() > 0 && cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		if (chk_i.pending() > 0) begin
			$display("timeout after %0d cycles with %0d stores still outstanding",
				cycles, chk_i.pending());
			chk_i.report_missing();
		end

		// the program now spins on its last jal, so any further store is stray
		cycles = 0;
		while (cycles < drain_cycles) begin
			@(posedge clock);
			cycles++;
		end

		$display("tests: %0d passed, %0d failed, %0d expected", chk_i.pass_count,
			chk_i.fail_count, n_expect);
		if (stim_ok && chk_i.fail_count == 0 && chk_i.pass_count == n_expect) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/core_stim.txt
# i <word>                  instruction, in program order from address 0
# d <addr> <word>           initial data memory word
# e <test> <addr> <data>    expected store, in the order stores happen
# forwarding chain
i 00c00093  addi x1, x0, 12
i 00a00113  addi x2, x0, 10
i 002081b3  add  x3, x1, x2
i 40118233  sub  x4, x3, x1
i 003272b3  and  x5, x4, x3
i 0012e333  or   x6, x5, x1
i 003343b3  xor  x7, x6, x3
i 00732433  slt  x8, x6, x7
i 10802a23  sw   x8, 0x114(x0)
i 10302023  sw   x3, 0x100(x0)
i 10402223  sw   x4, 0x104(x0)
i 10502423  sw   x5, 0x108(x0)
i 10602623  sw   x6, 0x10c(x0)
i 10702823  sw   x7, 0x110(x0)
# negative immediates and x0
i ff900493  addi x9, x0, -7
i f9c48513  addi x10, x9, -100
i 10902c23  sw   x9, 0x118(x0)
i 10a02e23  sw   x10, 0x11c(x0)
i 03750013  addi x0, x10, 55
i 12002023  sw   x0, 0x120(x0)
# load-use
i 04002603  lw   x12, 0x40(x0)
i 001606b3  add  x13, x12, x1
i 12d02223  sw   x13, 0x124(x0)
i 04402703  lw   x14, 0x44(x0)
i 12e02423  sw   x14, 0x128(x0)
# branches
i 00208463  beq  x1, x2, +8
i 12102623  sw   x1, 0x12c(x0)
i 00220663  beq  x4, x2, +12
i 12102823  sw   x1, 0x130(x0)
i 12202a23  sw   x2, 0x134(x0)
i 12402c23  sw   x4, 0x138(x0)
# jal
i 00c007ef  jal  x15, +12
i 12102e23  sw   x1, 0x13c(x0)
i 14202023  sw   x2, 0x140(x0)
i 14f02223  sw   x15, 0x144(x0)
i 0000006f  jal  x0, 0
# data words for the loads
d 00000040 00001234
d 00000044 0000beef
# expected stores
e slt_fwd 00000114 00000001
e add_fwd 00000100 00000016
e sub_fwd 00000104 0000000a
e and_fwd 00000108 00000002
e or_fwd 0000010c 0000000e
e xor_fwd 00000110 00000018
e addi_neg 00000118 fffffff9
e addi_neg_chain 0000011c ffffff95
e x0_write 00000120 00000000
e load_use_add 00000124 00001240
e load_use_store 00000128 0000beef
e beq_not_taken 0000012c 0000000c
e beq_taken 00000138 0000000a
e jal_link 00000144 00000080

// File: all.f
verilog/rv_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv_core.sv
tb/core_checker.sv
tb/tb_core.sv
